/* hw/ps2_kbd_pkg.sv */
package ps2_kbd_pkg;

    // One byte of scan set 2
    typedef logic [7:0] scan_t;

    // Key event as seen by the host, 18 bits
    typedef struct packed {
        logic [7:0] ascii;     // Zero for unmapped keys
        scan_t      scan;      // Final code of the sequence
        logic       released;  // Break seen before the code
        logic       extended;  // E0 seen before the code
    } key_event_t;

    // Prefix bytes
    localparam scan_t SCAN_BREAK  = 8'hF0;
    localparam scan_t SCAN_EXTEND = 8'hE0;

    // Modifier keys tracked by the decoder
    localparam scan_t SCAN_LSHIFT = 8'h12;
    localparam scan_t SCAN_RSHIFT = 8'h59;

    // Start, eight data bits, parity and stop
    localparam int FRAME_BITS = 11;

endpackage

/* hw/ps2_frame_rx.sv */
`timescale 1ns/10ps

module ps2_frame_rx import ps2_kbd_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  ps2_clk,
    input  logic  ps2_data,
    output logic  byte_valid,
    output scan_t byte_data,
    output logic  frame_error
);

    logic [2:0]            clk_sync;     // Stage 0 is the metastable one
    logic [1:0]            data_sync;
    logic                  sample;       // Falling edge of the PS/2 clock
    logic [3:0]            bit_cnt;
    logic [FRAME_BITS-1:0] frame;        // Bit 0 is the start bit
    logic                  frame_done;
    logic                  start_ok;
    logic                  stop_ok;
    logic                  parity_ok;
    logic                  frame_good;

    // Lines idle high, so the clock chain resets to one
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync <= 3'b111;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
        end
    end

    always_ff @(posedge clk) begin
        data_sync <= {data_sync[0], ps2_data};  // Same depth as the edge point
    end

    assign sample = clk_sync[2] & ~clk_sync[1];

    // Frame buffer, LSB first
    always_ff @(posedge clk) begin
        if (sample) begin
            frame <= {data_sync[1], frame[FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (sample) begin
                if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;                  // Stop bit just taken
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    assign start_ok   = ~frame[0];
    assign stop_ok    = frame[FRAME_BITS-1];
    assign parity_ok  = ^frame[FRAME_BITS-2:1];          // Odd over data and parity
    assign frame_good = start_ok & stop_ok & parity_ok;

    assign byte_valid  = frame_done & frame_good;
    assign frame_error = frame_done & ~frame_good;
    assign byte_data   = frame[8:1];

    a_rx_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(byte_valid && frame_error))
        else $error("byte_valid and frame_error high together");

endmodule

/* hw/scan_fifo.sv */
`timescale 1ns/10ps

module scan_fifo #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     full,
    output logic     overflow
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            wr_en;
    logic            rd_en;

    assign not_empty = (count != '0);
    assign full      = (count == CW'(DEPTH));
    assign rd_en     = pop & not_empty;
    assign wr_en     = push & (~full | rd_en);  // A slot frees up on the same edge

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head = mem[rd_ptr];  // Show-ahead

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !wr_en) begin
                overflow <= 1'b1;  // Sticky until reset
            end
        end
    end

    a_fifo_count: assert property (@(posedge clk) disable iff (rst)
        count <= CW'(DEPTH))
        else $error("FIFO count above depth");

    a_fifo_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> not_empty)
        else $error("Pop from an empty FIFO");

endmodule

/* hw/scan_ascii_map.sv */
`timescale 1ns/10ps

module scan_ascii_map import ps2_kbd_pkg::*; (
    input  scan_t      scan,
    input  logic       shift,
    output logic [7:0] ascii
);

    logic [7:0] letter;  // Uppercase code, zero if not a letter
    logic [7:0] digit;

    always_comb begin
        letter = 8'h00;
        digit  = 8'h00;
        case (scan)
            8'h1C: letter = 8'h41;  // A
            8'h32: letter = 8'h42;  // B
            8'h21: letter = 8'h43;
            8'h23: letter = 8'h44;
            8'h24: letter = 8'h45;  // E
            8'h2B: letter = 8'h46;
            8'h34: letter = 8'h47;
            8'h33: letter = 8'h48;
            8'h43: letter = 8'h49;  // I
            8'h3B: letter = 8'h4A;
            8'h42: letter = 8'h4B;
            8'h4B: letter = 8'h4C;
            8'h3A: letter = 8'h4D;  // M
            8'h31: letter = 8'h4E;
            8'h44: letter = 8'h4F;
            8'h4D: letter = 8'h50;
            8'h15: letter = 8'h51;  // Q
            8'h2D: letter = 8'h52;
            8'h1B: letter = 8'h53;
            8'h2C: letter = 8'h54;
            8'h3C: letter = 8'h55;  // U
            8'h2A: letter = 8'h56;
            8'h1D: letter = 8'h57;
            8'h22: letter = 8'h58;
            8'h35: letter = 8'h59;
            8'h1A: letter = 8'h5A;  // Z
            8'h45: digit  = 8'h30;  // 0
            8'h16: digit  = 8'h31;
            8'h1E: digit  = 8'h32;
            8'h26: digit  = 8'h33;
            8'h25: digit  = 8'h34;
            8'h2E: digit  = 8'h35;  // 5
            8'h36: digit  = 8'h36;
            8'h3D: digit  = 8'h37;
            8'h3E: digit  = 8'h38;
            8'h46: digit  = 8'h39;  // 9
            default: begin
                letter = 8'h00;
                digit  = 8'h00;
            end
        endcase
    end

    // Lowercase is uppercase with bit 5 set
    always_comb begin
        if (letter != 8'h00) begin
            ascii = shift ? letter : (letter | 8'h20);
        end else begin
            ascii = digit;
        end
    end

endmodule

/* hw/make_break_decoder.sv */
`timescale 1ns/10ps

module make_break_decoder import ps2_kbd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  scan_t      raw_byte,
    input  logic       raw_valid,
    output logic       raw_pop,
    input  logic       event_full,
    output logic       event_push,
    output key_event_t event_data
);

    logic       break_pend;   // F0 seen, waiting for the code
    logic       ext_pend;     // E0 seen
    logic       lshift_held;
    logic       rshift_held;
    logic       is_break;
    logic       is_extend;
    logic       final_byte;
    logic [7:0] map_ascii;

    scan_ascii_map i_ascii_map (
        .scan  (raw_byte),
        .shift (lshift_held | rshift_held),
        .ascii (map_ascii)
    );

    assign is_break   = (raw_byte == SCAN_BREAK);
    assign is_extend  = (raw_byte == SCAN_EXTEND);
    assign raw_pop    = raw_valid & ~event_full;  // Stall on a full event FIFO
    assign final_byte = raw_pop & ~is_break & ~is_extend;
    assign event_push = final_byte;

    always_comb begin
        event_data.ascii    = ext_pend ? 8'h00 : map_ascii;  // Extended keys are unmapped
        event_data.scan     = raw_byte;
        event_data.released = break_pend;
        event_data.extended = ext_pend;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            break_pend <= 1'b0;
            ext_pend   <= 1'b0;
        end else if (raw_pop) begin
            if (final_byte) begin
                break_pend <= 1'b0;  // Sequence complete
                ext_pend   <= 1'b0;
            end else begin
                if (is_break) begin
                    break_pend <= 1'b1;
                end
                if (is_extend) begin
                    ext_pend <= 1'b1;
                end
            end
        end
    end

    // E0 12 and E0 59 are other keys and leave shift alone
    always_ff @(posedge clk) begin
        if (rst) begin
            lshift_held <= 1'b0;
            rshift_held <= 1'b0;
        end else if (final_byte && !ext_pend) begin
            if (raw_byte == SCAN_LSHIFT) begin
                lshift_held <= ~break_pend;
            end
            if (raw_byte == SCAN_RSHIFT) begin
                rshift_held <= ~break_pend;
            end
        end
    end

    a_dec_no_push_full: assert property (@(posedge clk) disable iff (rst)
        event_push |-> !event_full)
        else $error("Event pushed into a full FIFO");

endmodule

/* hw/ps2_keyboard_top.sv */
`timescale 1ns/10ps

module ps2_keyboard_top import ps2_kbd_pkg::*; #(
    parameter int RAW_DEPTH   = 8,
    parameter int EVENT_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       next,
    output key_event_t key_event,       // Head of the event FIFO
    output logic       ready,
    output logic       raw_overflow,
    output logic       event_overflow,
    output logic       frame_error
);

    logic       rx_valid;
    scan_t      rx_data;
    scan_t      raw_head;
    logic       raw_not_empty;
    logic       raw_pop;
    logic       event_full;
    logic       event_push;
    key_event_t event_data;

    ps2_frame_rx i_frame_rx (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .byte_valid  (rx_valid),
        .byte_data   (rx_data),
        .frame_error (frame_error)
    );

    scan_fifo #(
        .DEPTH     (RAW_DEPTH),
        .payload_t (scan_t)
    ) i_raw_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_valid),
        .push_data (rx_data),
        .pop       (raw_pop),
        .head      (raw_head),
        .not_empty (raw_not_empty),
        .full      (),                  // Drops show up as overflow
        .overflow  (raw_overflow)
    );

    make_break_decoder i_decoder (
        .clk        (clk),
        .rst        (rst),
        .raw_byte   (raw_head),
        .raw_valid  (raw_not_empty),
        .raw_pop    (raw_pop),
        .event_full (event_full),
        .event_push (event_push),
        .event_data (event_data)
    );

    scan_fifo #(
        .DEPTH     (EVENT_DEPTH),
        .payload_t (key_event_t)
    ) i_event_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (event_push),
        .push_data (event_data),
        .pop       (next),
        .head      (key_event),
        .not_empty (ready),
        .full      (event_full),
        .overflow  (event_overflow)
    );

endmodule

/* test/ps2_device_tasks.svh */
`ifndef PS2_DEVICE_TASKS_SVH
`define PS2_DEVICE_TASKS_SVH

// One PS/2 bit of 20 clk cycles, called on a rising edge of clk
task automatic send_bit(input logic value);
    ps2_data <= value;
    ps2_clk  <= 1'b1;
    repeat (10) @(posedge clk);
    ps2_clk <= 1'b0;                 // Host samples on this falling edge
    repeat (10) @(posedge clk);
endtask

// Start, eight data bits LSB first, parity, stop
task automatic send_frame(input scan_t code, input logic bad_parity);
    logic parity;
    parity = ~(^code) ^ bad_parity;  // Odd over data and parity when good
    @(posedge clk);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
        send_bit(code[i]);
    end
    send_bit(parity);
    send_bit(1'b1);
    ps2_clk  <= 1'b1;
    ps2_data <= 1'b1;
    repeat (20) @(posedge clk);      // Idle gap
endtask

// A whole key, with prefixes, and its entry in the reference queue
task automatic press(input scan_t code, input logic released, input logic extended,
                     input logic stored);
    key_event_t ev;
    ev.ascii    = extended ? 8'h00 : expected_ascii(code, lshift | rshift);
    ev.scan     = code;
    ev.released = released;
    ev.extended = extended;
    if (stored) begin
        expected.push_back(ev);      // Before the last frame, pops come fast
    end
    if (extended) begin
        send_frame(SCAN_EXTEND, 1'b0);
    end
    if (released) begin
        send_frame(SCAN_BREAK, 1'b0);
    end
    send_frame(code, 1'b0);
    if (!extended && code == SCAN_LSHIFT) begin
        lshift = !released;
    end
    if (!extended && code == SCAN_RSHIFT) begin
        rshift = !released;
    end
endtask

`endif

/* test/tb_ps2_keyboard.sv */
`timescale 1ns/10ps

module tb_ps2_keyboard import ps2_kbd_pkg::*; ();

    localparam int TIMEOUT = 4000;   // clk cycles per wait

    logic       clk      = 1'b0;
    logic       rst      = 1'b1;
    logic       ps2_clk  = 1'b1;
    logic       ps2_data = 1'b1;
    logic       next     = 1'b0;
    key_event_t key_event;
    logic       ready;
    logic       raw_overflow;
    logic       event_overflow;
    logic       frame_error;

    key_event_t expected[$];         // Reference queue
    logic       lshift = 1'b0;
    logic       rshift = 1'b0;
    logic       host_en = 1'b1;
    logic       overflow_allowed = 1'b0;
    logic       bad_frame_sent = 1'b0;
    int         frame_errors = 0;
    int         mismatches = 0;
    int         other_errors = 0;
    int         timeouts = 0;
    string      test_name = "reset";

    // Set 2 codes, letters A to Z then digits 0 to 9
    scan_t key_codes [36] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };
    logic [7:0] key_chars [36] = '{
        "A", "B", "C", "D", "E", "F", "G", "H", "I", "J", "K", "L", "M",
        "N", "O", "P", "Q", "R", "S", "T", "U", "V", "W", "X", "Y", "Z",
        "0", "1", "2", "3", "4", "5", "6", "7", "8", "9"
    };

    function automatic logic [7:0] expected_ascii(input scan_t code, input logic shifted);
        logic [7:0] result;
        result = 8'h00;
        for (int i = 0; i < 36; i++) begin
            if (key_codes[i] == code) begin
                result = (i < 26 && !shifted) ? key_chars[i] + 8'h20 : key_chars[i];
            end
        end
        return result;
    endfunction

    function automatic scan_t pick_key(input logic letters_only);
        int idx;
        idx = letters_only ? $urandom_range(25, 0) : $urandom_range(35, 0);
        return key_codes[idx];
    endfunction

    `include "ps2_device_tasks.svh"

    ps2_keyboard_top #(
        .RAW_DEPTH   (4),
        .EVENT_DEPTH (4)
    ) i_ps2_keyboard_top (
        .clk            (clk),
        .rst            (rst),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .next           (next),
        .key_event      (key_event),
        .ready          (ready),
        .raw_overflow   (raw_overflow),
        .event_overflow (event_overflow),
        .frame_error    (frame_error)
    );

    always #5 clk = ~clk;

    // Host reads one event per strobe
    always @(posedge clk) begin
        if (rst || !host_en) begin
            next <= 1'b0;
        end else begin
            next <= ready && !next;
        end
    end

    always @(posedge clk) begin
        key_event_t exp_ev;
        if (frame_error) begin
            frame_errors++;
        end
        if (!rst && next && ready) begin
            if (expected.size() == 0) begin
                other_errors++;
                $display("Event %h in %s arrived with none expected", key_event, test_name);
            end else begin
                exp_ev = expected.pop_front();
                assert (key_event == exp_ev) else begin
                    mismatches++;
                    $display("Mismatch in %s: expected %h, actual %h",
                             test_name, exp_ev, key_event);
                end
            end
        end
    end

    a_pop_when_ready: assert property (@(posedge clk) disable iff (rst) next |-> ready)
        else begin
            other_errors++;
            $display("Host popped with ready low in %s", test_name);
        end

    a_no_event_overflow: assert property (@(posedge clk) disable iff (rst) !event_overflow)
        else begin
            other_errors++;
            $display("Event FIFO overflowed in %s", test_name);
        end

    a_raw_overflow_only_in_test: assert property (@(posedge clk) disable iff (rst)
        raw_overflow |-> overflow_allowed)
        else begin
            other_errors++;
            $display("Raw FIFO overflowed in %s", test_name);
        end

    a_frame_error_only_bad: assert property (@(posedge clk) disable iff (rst)
        frame_error |-> bad_frame_sent)
        else begin
            other_errors++;
            $display("Frame error on a good frame in %s", test_name);
        end

    task automatic wait_drained();
        int cnt;
        cnt = 0;
        while ((expected.size() != 0 || ready) && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt == TIMEOUT) begin
            timeouts++;
            $display("Timeout in %s waiting for %0d events", test_name, expected.size());
            expected.delete();
        end
    endtask

    task automatic wait_frame_error();
        int cnt;
        cnt = 0;
        while (frame_errors == 0 && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (frame_errors == 0) begin
            timeouts++;
            $display("Timeout in %s waiting for frame_error", test_name);
        end
    endtask

    task automatic wait_raw_overflow();
        int cnt;
        cnt = 0;
        while (!raw_overflow && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (!raw_overflow) begin
            timeouts++;
            $display("Timeout in %s waiting for raw_overflow", test_name);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        lshift = 1'b0;
        rshift = 1'b0;
        @(posedge clk);
    endtask

    initial begin
        scan_t code;
        void'($urandom(56555));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_name = "random_make";
        repeat (12) begin
            press(pick_key(1'b0), 1'b0, 1'b0, 1'b1);
        end
        wait_drained();

        test_name = "break_and_shift";
        code = pick_key(1'b0);
        press(code, 1'b0, 1'b0, 1'b1);
        press(code, 1'b1, 1'b0, 1'b1);
        for (int s = 0; s < 2; s++) begin
            code = (s == 0) ? SCAN_LSHIFT : SCAN_RSHIFT;
            press(code, 1'b0, 1'b0, 1'b1);
            press(pick_key(1'b1), 1'b0, 1'b0, 1'b1);  // Uppercase
            press(pick_key(1'b1), 1'b0, 1'b0, 1'b1);
            press(code, 1'b1, 1'b0, 1'b1);
            press(pick_key(1'b1), 1'b0, 1'b0, 1'b1);  // Lowercase again
        end
        wait_drained();

        test_name = "extended";
        code = pick_key(1'b0);
        press(code, 1'b0, 1'b1, 1'b1);
        press(code, 1'b1, 1'b1, 1'b1);
        press(SCAN_LSHIFT, 1'b0, 1'b1, 1'b1);       // E0 12 is not shift
        press(pick_key(1'b1), 1'b0, 1'b0, 1'b1);
        press(SCAN_LSHIFT, 1'b1, 1'b1, 1'b1);
        wait_drained();

        test_name = "bad_parity";
        bad_frame_sent = 1'b1;
        send_frame(pick_key(1'b0), 1'b1);
        wait_frame_error();
        bad_frame_sent = 1'b0;
        press(pick_key(1'b0), 1'b0, 1'b0, 1'b1);
        wait_drained();
        assert (frame_errors == 1) else begin
            mismatches++;
            $display("Mismatch in %s: expected %0d, actual %0d", test_name, 1, frame_errors);
        end

        test_name = "back_pressure";
        host_en = 1'b0;
        overflow_allowed = 1'b1;
        repeat (8) begin
            press(pick_key(1'b0), 1'b0, 1'b0, 1'b1);
        end
        press(pick_key(1'b0), 1'b0, 1'b0, 1'b0);      // Dropped at the raw FIFO
        wait_raw_overflow();
        assert (!event_overflow) else begin
            other_errors++;
            $display("Event overflow set under back-pressure");
        end
        host_en = 1'b1;
        wait_drained();

        test_name = "reset";
        apply_reset();
        overflow_allowed = 1'b0;
        assert (!ready && !raw_overflow && !event_overflow && !frame_error) else begin
            other_errors++;
            $display("Status flags not clear after reset");
        end
        repeat (5) @(posedge clk);

        $display("Errors: %0d mismatches, %0d other, %0d timeouts",
                 mismatches, other_errors, timeouts);
        if (mismatches + other_errors + timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+test
hw/ps2_kbd_pkg.sv
hw/ps2_frame_rx.sv
hw/scan_fifo.sv
hw/scan_ascii_map.sv
hw/make_break_decoder.sv
hw/ps2_keyboard_top.sv
test/tb_ps2_keyboard.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_ps2_keyboard -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
